// File: vlog.f
verilog/mem_bus_pkg.sv
verilog/mem_addr_pkg.sv
verilog/data_cache.sv
verilog/uncached_access.sv
verilog/axi_master.sv
verilog/mem_subsys_top.sv
testbench/axi_slave_model.sv
testbench/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - verilog/mem_bus_pkg.sv
  - verilog/mem_addr_pkg.sv
  - verilog/data_cache.sv
  - verilog/uncached_access.sv
  - verilog/axi_master.sv
  - verilog/mem_subsys_top.sv
  - target: test
    files:
      - testbench/axi_slave_model.sv
      - testbench/tb_mem_subsys.sv

// File: testbench/tb_mem_subsys.sv
module tb_mem_subsys
    import mem_bus_pkg::*, mem_addr_pkg::*;
();

    localparam int line_words  = 4;
    localparam int set_count   = 64;
    localparam int stall_limit = 2000;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic [3:0]  we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        stall;
    logic [3:0]  arid, arlen, arcache, rid, awid, awlen, awcache, wid, wstrb, bid;
    logic [31:0] araddr, axi_rdata, awaddr, axi_wdata;
    logic [2:0]  arsize, arprot, awsize, awprot;
    logic [1:0]  arburst, arlock, rresp, awburst, awlock, bresp;
    logic        arvalid, arready, rlast, rvalid, rready;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    // reference model, keyed by physical word address
    logic [31:0] model [logic [29:0]];
    string       test_name = "reset";
    logic        rst_q = 1'b0;
    logic        rd_pending = 1'b0;
    logic [31:0] exp_word = '0;
    logic [31:0] exp_q = '0;
    logic [31:0] slave_word = '0;
    logic [31:0] exp_wb = '0;
    logic [31:0] wb_addr = '0;
    logic [31:0] exp_paddr;
    logic        is_unc;
    int          wb_beat = 0;
    int          unc_xfers = 0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mem_subsys_top #(
        .LINE_WORDS (line_words),
        .SET_COUNT  (set_count)
    ) u_dut (.*);

    axi_slave_model #(
        .LINE_WORDS (line_words)
    ) u_slave (
        .rdata (axi_rdata),
        .wdata (axi_wdata),
        .*
    );

    function automatic logic [31:0] to_phys(input logic [31:0] a);
        if (a[31:29] == seg_kseg0 || a[31:29] == seg_kseg1) begin
            return {3'b000, a[28:0]};
        end
        return a;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] pa);
        if (model.exists(pa[31:2])) begin
            return model[pa[31:2]];
        end
        return {pa[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_on_error($sformatf("MISMATCH %s %s: expected %h actual %h",
                                test_name, what, exp, act));
    endtask

    // one core request, held until stall is low
    task automatic do_access(input logic [31:0] a, input logic [3:0] strb,
                             input logic [31:0] d);
        logic [31:0] pa;
        int          waited;
        pa       = to_phys(a);
        en       = 1'b1;
        we       = strb;
        addr     = a;
        wdata    = d;
        exp_word = merge_bytes(model_word(pa), d, strb);
        waited   = 0;
        #1;
        while (stall && waited < stall_limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (stall) begin
            stop_on_error($sformatf("%s: stall never fell for address %h", test_name, a));
        end
        slave_word = u_slave.read_word(pa);
        if (strb != 4'b0000) begin
            model[pa[31:2]] = exp_word;
        end
        @(negedge clk);
        en = 1'b0;
    endtask

    assign exp_paddr = to_phys(addr);
    assign is_unc    = (addr[31:29] == seg_kseg1);

    always @(posedge clk) begin
        rst_q      <= rst_n;
        rd_pending <= rst_n && en && !stall && we == 4'b0000;
        exp_q      <= exp_word;
        if (awvalid && awready && awid == bus_id_cache) begin
            wb_addr <= awaddr;
            wb_beat <= 0;
        end else if (wvalid && wready && wid == bus_id_cache) begin
            wb_addr <= wb_addr + 32'd4;
            wb_beat <= wb_beat + 1;
        end
        if (en && !stall && is_unc) begin
            unc_xfers <= 0;
        end else if ((arvalid && arready && arid == bus_id_uncached) ||
                     (awvalid && awready && awid == bus_id_uncached)) begin
            unc_xfers <= unc_xfers + 1;
        end
    end

    // line word the current write-back beat should carry
    always @(negedge clk) begin
        exp_wb = model_word(wb_addr);
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_q |-> !stall && !arvalid && !awvalid && !wvalid)
        else stop_on_error("stall or an AXI valid was high during or right after reset");

    a_read_data: assert property (@(posedge clk) rd_pending |-> rdata == exp_q)
        else report_mismatch("read data", $sampled(exp_q), $sampled(rdata));

    a_refill_burst: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arid == bus_id_cache |-> arlen == 4'(line_words - 1) &&
            arburst == burst_incr && arsize == size_word && araddr % (line_words * 4) == 0)
        else stop_on_error("refill burst has a wrong length, type, size or alignment");

    a_ar_attr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arcache == cache_attr && arprot == prot_attr && arlock == lock_normal)
        else stop_on_error("read address carries wrong cache, protection or lock attributes");

    a_aw_attr: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> awcache == cache_attr && awprot == prot_attr && awlock == lock_normal)
        else stop_on_error("write address carries wrong cache, protection or lock attributes");

    a_wb_burst: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awid == bus_id_cache |-> awlen == 4'(line_words - 1) &&
            awburst == burst_incr && awsize == size_word)
        else stop_on_error("write-back burst has a wrong length, type or size");

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wid == bus_id_cache |-> axi_wdata == exp_wb)
        else report_mismatch("write-back data", $sampled(exp_wb), $sampled(axi_wdata));

    a_wb_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wid == bus_id_cache |-> wlast == (wb_beat == line_words - 1) &&
            wstrb == 4'hf)
        else stop_on_error("write-back beat has a misplaced wlast or partial strobes");

    a_unc_read: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arid == bus_id_uncached |-> arlen == 4'd0 && araddr == exp_paddr)
        else stop_on_error("uncached read is not one beat at the translated address");

    a_unc_write: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awid == bus_id_uncached |-> awlen == 4'd0 && awaddr == exp_paddr)
        else stop_on_error("uncached write is not one beat at the translated address");

    a_unc_beat: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wid == bus_id_uncached |-> axi_wdata == wdata && wstrb == we && wlast)
        else stop_on_error("uncached write beat does not carry the core data and strobes");

    a_unc_once: assert property (@(posedge clk) disable iff (!rst_n)
        en && !stall && is_unc |-> unc_xfers == 1)
        else report_mismatch("uncached transfer count", 32'd1, 32'($sampled(unc_xfers)));

    a_unc_mem: assert property (@(posedge clk) disable iff (!rst_n)
        en && !stall && is_unc && we != 4'b0000 |-> slave_word == exp_word)
        else report_mismatch("uncached write in memory", $sampled(exp_word),
                             $sampled(slave_word));

    initial begin
        logic [31:0] a;
        logic [3:0]  strb;
        void'($urandom(659));
        rst_n = 1'b0;
        en    = 1'b0;
        we    = 4'b0000;
        addr  = '0;
        wdata = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        test_name = "cached read after write";
        do_access(32'h8000_0100, 4'b0000, 32'd0);
        do_access(32'h8000_0104, 4'b1111, 32'h1234_5678);
        do_access(32'h8000_0104, 4'b0000, 32'd0);
        do_access(32'h8000_0100, 4'b0000, 32'd0);

        test_name = "byte strobes";
        do_access(32'h8000_0108, 4'b0010, 32'haabb_ccdd);
        do_access(32'h8000_0108, 4'b0000, 32'd0);
        do_access(32'ha010_0010, 4'b1001, 32'h1122_3344);
        do_access(32'ha010_0010, 4'b0000, 32'd0);

        // same index as the dirty line at 0x100, other tag
        test_name = "write-back";
        do_access(32'h8000_0504, 4'b0000, 32'd0);
        do_access(32'h8000_0104, 4'b0000, 32'd0);

        test_name = "uncached";
        do_access(32'ha010_0020, 4'b1111, 32'hcafe_f00d);
        do_access(32'ha010_0020, 4'b0000, 32'd0);
        do_access(32'ha010_0024, 4'b0000, 32'd0);

        // cached and uncached windows do not alias
        test_name = "random mix";
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(1) == 0) begin
                a = 32'h8000_0000 | ($urandom & 32'h0000_0ffc);
            end else begin
                a = 32'ha010_0000 | ($urandom & 32'h0000_003c);
            end
            if ($urandom_range(1) == 0) begin
                strb = 4'b0000;
            end else begin
                strb = 4'($urandom_range(15, 1));
            end
            do_access(a, strb, $urandom);
        end

        repeat (4) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: testbench/axi_slave_model.sv
module axi_slave_model #(
    parameter int LINE_WORDS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready = 1'b0,
    output logic [3:0]  rid = 4'd0,
    output logic [31:0] rdata = 32'd0,
    output logic [1:0]  rresp,
    output logic        rlast = 1'b0,
    output logic        rvalid = 1'b0,
    input  logic        rready,
    input  logic [3:0]  awid,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready = 1'b0,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready = 1'b0,
    output logic [3:0]  bid = 4'd0,
    output logic [1:0]  bresp,
    output logic        bvalid = 1'b0,
    input  logic        bready
);

    // bursts never run longer than one cache line
    localparam int left_w = $clog2(LINE_WORDS) + 1;

    logic [31:0]       mem [logic [29:0]];
    logic [31:0]       rd_addr;
    logic [31:0]       wr_addr;
    logic [left_w-1:0] rd_left;
    logic [3:0]        rd_id;
    logic [3:0]        wr_id;
    logic              rd_busy;
    logic              wr_busy;
    logic              b_pend;
    logic              r_hs;
    logic              b_hs;

    assign rresp = 2'b00;
    assign bresp = 2'b00;

    // untouched words read back as their own address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[31:2], 2'b00};
    endfunction

    always @(posedge clk) begin
        logic [31:0] word;
        r_hs <= rvalid && rready;
        b_hs <= bvalid && bready;
        if (!rst_n) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_left <= left_w'(arlen);
                rd_id   <= arid;
            end
            if (rvalid && rready) begin
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 1'b1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_addr <= awaddr;
                wr_id   <= awid;
            end
            if (wvalid && wready) begin
                word = read_word(wr_addr);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        word[b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
                mem[wr_addr[31:2]] = word;
                wr_addr <= wr_addr + 32'd4;
                if (wlast) begin
                    b_pend <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

    // ready and valid gaps chosen on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            arready <= !rd_busy && ($urandom_range(3) != 0);
            awready <= !wr_busy && ($urandom_range(3) != 0);
            wready  <= wr_busy && !b_pend && ($urandom_range(3) != 0);
            // a shown beat stays until it is taken
            if (!rvalid || r_hs) begin
                rvalid <= rd_busy && ($urandom_range(2) != 0);
                rdata  <= read_word(rd_addr);
                rlast  <= (rd_left == 0);
                rid    <= rd_id;
            end
            if (!bvalid || b_hs) begin
                bvalid <= b_pend && ($urandom_range(2) != 0);
                bid    <= wr_id;
            end
        end
    end

endmodule

// File: verilog/mem_subsys_top.sv
module mem_subsys_top import mem_addr_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int SET_COUNT  = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [3:0]  we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        stall,

    output logic [3:0]  arid,
    output logic [31:0] araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [1:0]  arlock,
    output logic [3:0]  arcache,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  rid,
    input  logic [31:0] axi_rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,

    output logic [3:0]  awid,
    output logic [31:0] awaddr,
    output logic [3:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic [1:0]  awlock,
    output logic [3:0]  awcache,
    output logic [2:0]  awprot,
    output logic        awvalid,
    input  logic        awready,
    output logic [3:0]  wid,
    output logic [31:0] axi_wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic [3:0]  bid,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    output logic        bready
);

    mem_addr_u                va;
    logic                     cached;
    logic                     cached_r;
    logic [31:0]              paddr;
    logic                     cache_en;
    logic                     unc_en;
    logic [31:0]              cache_rdata;
    logic                     cache_stall;
    logic [31:0]              unc_rdata;
    logic                     unc_stall;
    logic                     fill_req;
    logic [31:0]              fill_addr;
    logic                     fill_done;
    logic [LINE_WORDS*32-1:0] fill_line;
    logic                     evict_req;
    logic [31:0]              evict_addr;
    logic [LINE_WORDS*32-1:0] evict_line;
    logic                     evict_done;
    logic                     bus_req;
    logic [3:0]               bus_we;
    logic [31:0]              bus_addr;
    logic [31:0]              bus_wdata;
    logic                     bus_done;
    logic [31:0]              bus_rdata;

    assign va = addr;

    // kseg0/kseg1 drop the segment bits, kseg1 bypasses the cache
    always_comb begin
        cached = (va.seg.seg != seg_kseg1);
        paddr  = addr;
        if (va.seg.seg == seg_kseg0 || va.seg.seg == seg_kseg1) begin
            paddr = {3'b000, va.seg.offset};
        end
    end

    assign cache_en = en && cached;
    assign unc_en   = en && !cached;
    assign stall    = cache_stall || unc_stall;

    // read word shows up a cycle after acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cached_r <= 1'b0;
        end else if (en && !stall) begin
            cached_r <= cached;
        end
    end

    assign rdata = cached_r ? cache_rdata : unc_rdata;

    data_cache #(
        .LINE_WORDS (LINE_WORDS),
        .SET_COUNT  (SET_COUNT)
    ) u_cache (.*);

    uncached_access u_uncached (.*);

    axi_master #(
        .LINE_WORDS (LINE_WORDS)
    ) u_axi (
        .rdata (axi_rdata),
        .wdata (axi_wdata),
        .*
    );

endmodule

// File: verilog/axi_master.sv
module axi_master import mem_bus_pkg::*; #(
    parameter int LINE_WORDS = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     fill_req,
    input  logic [31:0]              fill_addr,
    output logic                     fill_done,
    output logic [LINE_WORDS*32-1:0] fill_line,
    input  logic                     evict_req,
    input  logic [31:0]              evict_addr,
    input  logic [LINE_WORDS*32-1:0] evict_line,
    output logic                     evict_done,

    input  logic                     bus_req,
    input  logic [3:0]               bus_we,
    input  logic [31:0]              bus_addr,
    input  logic [31:0]              bus_wdata,
    output logic                     bus_done,
    output logic [31:0]              bus_rdata,

    output logic [3:0]               arid,
    output logic [31:0]              araddr,
    output logic [3:0]               arlen,
    output logic [2:0]               arsize,
    output logic [1:0]               arburst,
    output logic [1:0]               arlock,
    output logic [3:0]               arcache,
    output logic [2:0]               arprot,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [3:0]               rid,
    input  logic [31:0]              rdata,
    input  logic [1:0]               rresp,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    output logic [3:0]               awid,
    output logic [31:0]              awaddr,
    output logic [3:0]               awlen,
    output logic [2:0]               awsize,
    output logic [1:0]               awburst,
    output logic [1:0]               awlock,
    output logic [3:0]               awcache,
    output logic [2:0]               awprot,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [3:0]               wid,
    output logic [31:0]              wdata,
    output logic [3:0]               wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [3:0]               bid,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready
);

    localparam int beat_w = $clog2(LINE_WORDS);
    localparam logic [beat_w-1:0] last_beat = beat_w'(LINE_WORDS - 1);

    localparam logic [1:0] r_idle = 2'd0;
    localparam logic [1:0] r_addr = 2'd1;
    localparam logic [1:0] r_data = 2'd2;
    localparam logic [1:0] r_done = 2'd3;

    localparam logic [2:0] w_idle = 3'd0;
    localparam logic [2:0] w_addr = 3'd1;
    localparam logic [2:0] w_data = 3'd2;
    localparam logic [2:0] w_resp = 3'd3;
    localparam logic [2:0] w_done = 3'd4;

    logic [1:0]               r_state;
    logic [2:0]               w_state;
    logic                     r_cache;
    logic                     w_cache;
    logic [beat_w-1:0]        r_beat;
    logic [beat_w-1:0]        w_beat;
    logic [LINE_WORDS*32-1:0] rd_buf;
    logic [LINE_WORDS*32-1:0] wr_buf;
    logic [3:0]               wr_strb;
    logic                     both_idle;
    logic                     start_rd;
    logic                     start_wr;

    // write-back, then refill, then uncached; only one transfer at a time
    assign both_idle = (r_state == r_idle) && (w_state == w_idle);
    assign start_wr  = both_idle && (evict_req || (bus_req && !fill_req && bus_we != 4'b0000));
    assign start_rd  = both_idle && !evict_req && (fill_req || (bus_req && bus_we == 4'b0000));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= r_idle;
            r_cache <= 1'b0;
            r_beat  <= '0;
        end else begin
            case (r_state)
                r_idle: begin
                    if (start_rd) begin
                        r_state <= r_addr;
                        r_cache <= fill_req;
                        r_beat  <= '0;
                    end
                end
                r_addr: begin
                    if (arready) begin
                        r_state <= r_data;
                    end
                end
                r_data: begin
                    if (rvalid) begin
                        r_beat <= r_beat + 1'b1;
                        if (rlast) begin
                            r_state <= r_done;
                        end
                    end
                end
                default: r_state <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state <= w_idle;
            w_cache <= 1'b0;
            w_beat  <= '0;
        end else begin
            case (w_state)
                w_idle: begin
                    if (start_wr) begin
                        w_state <= w_addr;
                        w_cache <= evict_req;
                        w_beat  <= '0;
                    end
                end
                w_addr: begin
                    if (awready) begin
                        w_state <= w_data;
                    end
                end
                w_data: begin
                    if (wready) begin
                        w_beat <= w_beat + 1'b1;
                        if (wlast) begin
                            w_state <= w_resp;
                        end
                    end
                end
                w_resp: begin
                    if (bvalid) begin
                        w_state <= w_done;
                    end
                end
                default: w_state <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_rd) begin
            araddr <= fill_req ? fill_addr : bus_addr;
        end
        if (rvalid && rready) begin
            rd_buf[r_beat*32 +: 32] <= rdata;
        end
        if (start_wr) begin
            awaddr  <= evict_req ? evict_addr : bus_addr;
            wr_buf  <= evict_req ? evict_line : (LINE_WORDS*32)'(bus_wdata);
            wr_strb <= evict_req ? 4'hf : bus_we;
        end
    end

    assign arid    = r_cache ? bus_id_cache : bus_id_uncached;
    assign arlen   = r_cache ? 4'(LINE_WORDS - 1) : 4'd0;
    assign arsize  = size_word;
    assign arburst = burst_incr;
    assign arlock  = lock_normal;
    assign arcache = cache_attr;
    assign arprot  = prot_attr;
    assign arvalid = (r_state == r_addr);
    assign rready  = (r_state == r_data);

    assign awid    = w_cache ? bus_id_cache : bus_id_uncached;
    assign awlen   = w_cache ? 4'(LINE_WORDS - 1) : 4'd0;
    assign awsize  = size_word;
    assign awburst = burst_incr;
    assign awlock  = lock_normal;
    assign awcache = cache_attr;
    assign awprot  = prot_attr;
    assign awvalid = (w_state == w_addr);
    assign wid     = awid;
    assign wdata   = wr_buf[w_beat*32 +: 32];
    assign wstrb   = wr_strb;
    assign wlast   = !w_cache || (w_beat == last_beat);
    assign wvalid  = (w_state == w_data);
    assign bready  = (w_state == w_resp);

    assign fill_line  = rd_buf;
    assign bus_rdata  = rd_buf[31:0];
    assign fill_done  = (r_state == r_done) && r_cache;
    assign evict_done = (w_state == w_done) && w_cache;
    assign bus_done   = ((r_state == r_done) && !r_cache) || ((w_state == w_done) && !w_cache);

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // last beat of a line burst, never the one before it
    a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
        (awvalid && awready && awlen == 4'(LINE_WORDS - 1)) |=>
            ((wvalid && wready)[->LINE_WORDS-1] ##0 !wlast)
            ##1 ((wvalid && wready)[->1] ##0 wlast));

endmodule

// File: verilog/uncached_access.sv
module uncached_access (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        unc_en,
    input  logic [3:0]  we,
    input  logic [31:0] paddr,
    input  logic [31:0] wdata,
    output logic [31:0] unc_rdata,
    output logic        unc_stall,
    output logic        bus_req,
    output logic [3:0]  bus_we,
    output logic [31:0] bus_addr,
    output logic [31:0] bus_wdata,
    input  logic        bus_done,
    input  logic [31:0] bus_rdata
);

    logic served;

    // held until the repeat of the request finds the transfer done
    assign unc_stall = unc_en && !served;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_req <= 1'b0;
            served  <= 1'b0;
        end else if (bus_done) begin
            bus_req <= 1'b0;
            served  <= 1'b1;
        end else if (unc_en && served) begin
            served <= 1'b0;
        end else if (unc_en && !bus_req) begin
            bus_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (unc_en && !bus_req && !served) begin
            bus_we    <= we;
            bus_addr  <= paddr;
            bus_wdata <= wdata;
        end
        if (bus_done) begin
            unc_rdata <= bus_rdata;
        end
    end

    // the request is still up when the transfer completes
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus_done |-> bus_req);

endmodule

// File: verilog/data_cache.sv
module data_cache import mem_addr_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int SET_COUNT  = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cache_en,
    input  logic [3:0]               we,
    input  logic [31:0]              paddr,
    input  logic [31:0]              wdata,
    output logic [31:0]              cache_rdata,
    output logic                     cache_stall,
    output logic                     fill_req,
    output logic [31:0]              fill_addr,
    input  logic                     fill_done,
    input  logic [LINE_WORDS*32-1:0] fill_line,
    output logic                     evict_req,
    output logic [31:0]              evict_addr,
    output logic [LINE_WORDS*32-1:0] evict_line,
    input  logic                     evict_done
);

    localparam int word_w  = $clog2(LINE_WORDS);
    localparam int index_w = $clog2(SET_COUNT);
    localparam int tag_w   = 30 - word_w - index_w;

    localparam logic [1:0] s_idle    = 2'd0;
    localparam logic [1:0] s_wback   = 2'd1;
    localparam logic [1:0] s_refill  = 2'd2;
    localparam logic [1:0] s_install = 2'd3;

    mem_addr_u                pa;
    logic [29:0]              word_addr;
    logic [word_w-1:0]        word_sel;
    logic [index_w-1:0]       index;
    logic [tag_w-1:0]         tag;
    logic                     hit;
    logic                     accept;
    logic [1:0]               state;
    logic [index_w-1:0]       miss_index;
    logic [tag_w-1:0]         miss_tag;
    logic [LINE_WORDS*32-1:0] fill_buf;
    logic [LINE_WORDS*32-1:0] line_mem [SET_COUNT];
    logic [tag_w-1:0]         tag_mem [SET_COUNT];
    logic [SET_COUNT-1:0]     valid;
    logic [SET_COUNT-1:0]     dirty;

    // re-slice the word address so other geometries still work
    assign pa        = paddr;
    assign word_addr = {pa.cache.tag, pa.cache.index, pa.cache.word};
    assign word_sel  = word_addr[word_w-1:0];
    assign index     = word_addr[word_w +: index_w];
    assign tag       = word_addr[29 -: tag_w];

    assign hit         = valid[index] && (tag_mem[index] == tag);
    assign cache_stall = cache_en && (state != s_idle || !hit);
    assign accept      = cache_en && !cache_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            valid <= '0;
            dirty <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (accept && we != 4'b0000) begin
                        dirty[index] <= 1'b1;
                    end else if (cache_en && !hit) begin
                        // dirty victim goes out before the refill
                        state <= (valid[index] && dirty[index]) ? s_wback : s_refill;
                    end
                end
                s_wback: begin
                    if (evict_done) begin
                        state <= s_refill;
                    end
                end
                s_refill: begin
                    if (fill_done) begin
                        state <= s_install;
                    end
                end
                default: begin
                    valid[miss_index] <= 1'b1;
                    dirty[miss_index] <= 1'b0;
                    state             <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && cache_en && !hit) begin
            miss_index <= index;
            miss_tag   <= tag;
        end
        if (fill_done) begin
            fill_buf <= fill_line;
        end
        if (accept) begin
            cache_rdata <= line_mem[index][word_sel*32 +: 32];
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    line_mem[index][word_sel*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        if (state == s_install) begin
            line_mem[miss_index] <= fill_buf;
            tag_mem[miss_index]  <= miss_tag;
        end
    end

    assign evict_req  = (state == s_wback);
    assign fill_req   = (state == s_refill);
    assign fill_addr  = {miss_tag, miss_index, {(word_w + 2){1'b0}}};
    assign evict_addr = {tag_mem[miss_index], miss_index, {(word_w + 2){1'b0}}};
    assign evict_line = line_mem[miss_index];

    // refill and write-back never complete together
    a_one_line_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(fill_done && evict_done));

    // bus controller must not answer a refill that was never asked for
    a_fill_done_req: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> fill_req);

endmodule

// File: verilog/mem_addr_pkg.sv
package mem_addr_pkg;

    // top three address bits of the unmapped segments
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] offset;
    } seg_view_t;

    // default geometry: 64 sets of 4 words
    typedef struct packed {
        logic [21:0] tag;
        logic [5:0]  index;
        logic [1:0]  word;
        logic [1:0]  byte_off;
    } cache_view_t;

    typedef union packed {
        seg_view_t   seg;
        cache_view_t cache;
    } mem_addr_u;

endpackage

// File: verilog/mem_bus_pkg.sv
package mem_bus_pkg;

    // transaction ids
    localparam logic [3:0] bus_id_cache    = 4'd1;
    localparam logic [3:0] bus_id_uncached = 4'd2;

    // burst and beat encodings
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [2:0] size_word   = 3'b010;
    localparam logic [1:0] lock_normal = 2'b00;

    // fixed attributes on both address channels
    localparam logic [3:0] cache_attr = 4'b0000;
    localparam logic [2:0] prot_attr  = 3'b000;

endpackage
